//--- verilog.f
+incdir+.
idu_pkg.sv
inst_decoder.sv
imm_gen.sv
issue_ctrl.sv
d2e_stage.sv
idu_top.sv
tb_idu.sv

//--- Makefile
# build and run the testbench, pass only when the pass line shows up
all: obj_dir/Vtb_idu
	@out="$$(./obj_dir/Vtb_idu)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

obj_dir/Vtb_idu: verilog.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --top-module tb_idu -f verilog.f

lint:
	verilator --lint-only -Wall --timing --top-module tb_idu -f verilog.f

clean:
	rm -rf obj_dir

.PHONY: all lint clean

//--- tb_idu.sv
`timescale 1ns/10ps
`default_nettype none

`include "idu_defs.svh"

module tb_idu
   import idu_pkg::*;
();

   typedef struct {
      string       name;
      logic [31:0] word;
      logic        valid;
      // unit valids alu/lsu/bru/mul, wens alu/lsu/mul/link, b_imm, pc_rel, exception
      logic [10:0] flags;
      // alu op, lsu op, bru op, mul signed, mul hi
      logic [7:0]  ops;
      logic [4:0]  target;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [31:0] imm;
      logic [5:0]  code;
   } case_t;

   logic                 clk;
   logic                 rst_n;
   logic [31:0]          inst;
   logic [`GRLEN-1:0]    pc;
   logic                 inst_valid;
   logic [`GRLEN-1:0]    rs1_data;
   logic [`GRLEN-1:0]    rs2_data;
   logic [`REG_BITS-1:0] rs1_addr;
   logic [`REG_BITS-1:0] rs2_addr;
   exec_ctrl_t           ctrl_e;

   case_t       cases[$];
   logic [31:0] lfsr_state = 32'h0199_8d95;

   idu_top idu_top_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .inst       (inst),
      .pc         (pc),
      .inst_valid (inst_valid),
      .rs1_data   (rs1_data),
      .rs2_data   (rs2_data),
      .rs1_addr   (rs1_addr),
      .rs2_addr   (rs2_addr),
      .ctrl_e     (ctrl_e)
   );

   always #50 clk = ~clk;

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   // galois lfsr stepped once per bit
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
      return b;
   endfunction

   function automatic logic [31:0] rand_word();
      logic [31:0] w;
      w = '0;
      for (int k = 0; k < 32; k++)
         w = {w[30:0], lfsr_bit()};
      return w;
   endfunction

   task automatic check(input string name, input string field,
                        input logic [31:0] expected, input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Error: %s %s expected %h actual %h", name, field, expected, actual);
         $display("Simulation finished: FAIL");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic add_case(input string name, input logic [31:0] word, input logic valid,
                           input logic [10:0] flags, input logic [7:0] ops,
                           input logic [4:0] target, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [31:0] imm,
                           input logic [5:0] code);
      case_t c;
      c.name   = name;
      c.word   = word;
      c.valid  = valid;
      c.flags  = flags;
      c.ops    = ops;
      c.target = target;
      c.rs1    = rs1;
      c.rs2    = rs2;
      c.imm    = imm;
      c.code   = code;
      cases.push_back(c);
   endtask

   ////////////////////////////////////////
   // stimulus table
   ////////////////////////////////////////

   task automatic build_table();
      add_case("add.w", {`OP_ADD_W, 5'd5, 5'd4, 5'd3}, 1'b1,
               11'b1000_1000_000, 8'b000_0_00_00, 5'd3, 5'd4, 5'd5, 32'h0, 6'h0);
      add_case("sub.w", {`OP_SUB_W, 5'd7, 5'd8, 5'd9}, 1'b1,
               11'b1000_1000_000, 8'b001_0_00_00, 5'd9, 5'd8, 5'd7, 32'h0, 6'h0);
      add_case("and", {`OP_AND, 5'd10, 5'd11, 5'd12}, 1'b1,
               11'b1000_1000_000, 8'b010_0_00_00, 5'd12, 5'd11, 5'd10, 32'h0, 6'h0);
      add_case("or", {`OP_OR, 5'd13, 5'd14, 5'd15}, 1'b1,
               11'b1000_1000_000, 8'b011_0_00_00, 5'd15, 5'd14, 5'd13, 32'h0, 6'h0);
      add_case("xor", {`OP_XOR, 5'd31, 5'd0, 5'd30}, 1'b1,
               11'b1000_1000_000, 8'b100_0_00_00, 5'd30, 5'd0, 5'd31, 32'h0, 6'h0);
      add_case("addi.w pos", {`OP_ADDI_W, 12'h123, 5'd6, 5'd2}, 1'b1,
               11'b1000_1000_100, 8'b000_0_00_00, 5'd2, 5'd6, 5'd3, 32'h0000_0123, 6'h0);
      add_case("addi.w neg", {`OP_ADDI_W, 12'h800, 5'd1, 5'd17}, 1'b1,
               11'b1000_1000_100, 8'b000_0_00_00, 5'd17, 5'd1, 5'd0, 32'hFFFF_F800, 6'h0);
      add_case("pcaddu12i", {`OP_PCADDU12I, 20'h12345, 5'd7}, 1'b1,
               11'b1000_1000_110, 8'b000_0_00_00, 5'd7, 5'd5, 5'd26, 32'h1234_5000, 6'h0);
      add_case("pcaddu12i neg", {`OP_PCADDU12I, 20'hFFFFF, 5'd1}, 1'b1,
               11'b1000_1000_110, 8'b000_0_00_00, 5'd1, 5'd31, 5'd31, 32'hFFFF_F000, 6'h0);
      add_case("ld.w", {`OP_LD_W, 12'hFFC, 5'd3, 5'd10}, 1'b1,
               11'b0100_0100_000, 8'b000_0_00_00, 5'd10, 5'd3, 5'd28, 32'hFFFF_FFFC, 6'h0);
      add_case("st.w", {`OP_ST_W, 12'h010, 5'd4, 5'd11}, 1'b1,
               11'b0100_0000_000, 8'b000_1_00_00, 5'd11, 5'd4, 5'd11, 32'h0000_0010, 6'h0);
      add_case("beq", {`OP_BEQ, 16'h0010, 5'd5, 5'd6}, 1'b1,
               11'b0010_0000_000, 8'b000_0_00_00, 5'd6, 5'd5, 5'd6, 32'h0000_0040, 6'h0);
      add_case("bne", {`OP_BNE, 16'hFFFE, 5'd7, 5'd8}, 1'b1,
               11'b0010_0000_000, 8'b000_0_01_00, 5'd8, 5'd7, 5'd8, 32'hFFFF_FFF8, 6'h0);
      add_case("bl", {`OP_BL, 16'h1234, 5'd0, 5'd21}, 1'b1,
               11'b0010_0001_000, 8'b000_0_10_00, 5'd1, 5'd0, 5'd20, 32'h0054_48D0, 6'h0);
      add_case("bl neg", {`OP_BL, 16'hFFF0, 5'd31, 5'd31}, 1'b1,
               11'b0010_0001_000, 8'b000_0_10_00, 5'd1, 5'd31, 5'd16, 32'hFFFF_FFC0, 6'h0);
      add_case("mul.w", {`OP_MUL_W, 5'd2, 5'd3, 5'd4}, 1'b1,
               11'b0001_0010_000, 8'b000_0_00_10, 5'd4, 5'd3, 5'd2, 32'h0, 6'h0);
      add_case("mulh.w", {`OP_MULH_W, 5'd5, 5'd6, 5'd7}, 1'b1,
               11'b0001_0010_000, 8'b000_0_00_11, 5'd7, 5'd6, 5'd5, 32'h0, 6'h0);
      add_case("mulh.wu", {`OP_MULH_WU, 5'd8, 5'd9, 5'd10}, 1'b1,
               11'b0001_0010_000, 8'b000_0_00_01, 5'd10, 5'd9, 5'd8, 32'h0, 6'h0);
      add_case("syscall", {`OP_SYSCALL, 5'd0, 5'd1, 5'd2}, 1'b1,
               11'b0000_0000_001, 8'b000_0_00_00, 5'd2, 5'd1, 5'd0, 32'h0, `EXC_SYS);
      add_case("break", {`OP_BREAK, 5'd0, 5'd0, 5'd5}, 1'b1,
               11'b0000_0000_001, 8'b000_0_00_00, 5'd5, 5'd0, 5'd0, 32'h0, `EXC_BRK);
      add_case("ine ones", 32'hFFFF_FFFF, 1'b1,
               11'b0000_0000_001, 8'b000_0_00_00, 5'd31, 5'd31, 5'd31, 32'h0, `EXC_INE);
      add_case("ine zero", 32'h0000_0000, 1'b1,
               11'b0000_0000_001, 8'b000_0_00_00, 5'd0, 5'd0, 5'd0, 32'h0, `EXC_INE);
      // killed words still carry their data fields
      add_case("killed add.w", {`OP_ADD_W, 5'd1, 5'd2, 5'd3}, 1'b0,
               11'b0, 8'b000_0_00_00, 5'd3, 5'd2, 5'd1, 32'h0, 6'h0);
      add_case("killed ld.w", {`OP_LD_W, 12'h004, 5'd9, 5'd12}, 1'b0,
               11'b0, 8'b000_0_00_00, 5'd12, 5'd9, 5'd4, 32'h0000_0004, 6'h0);
      add_case("killed addi.w", {`OP_ADDI_W, 12'h7FF, 5'd1, 5'd2}, 1'b0,
               11'b0, 8'b000_0_00_00, 5'd2, 5'd1, 5'd31, 32'h0000_07FF, 6'h0);
      add_case("killed syscall", {`OP_SYSCALL, 5'd0, 5'd3, 5'd4}, 1'b0,
               11'b0, 8'b000_0_00_00, 5'd4, 5'd3, 5'd0, 32'h0, `EXC_SYS);
   endtask

   ////////////////////////////////////////
   // checks on the registered bundle
   ////////////////////////////////////////

   task automatic check_ctrl(input case_t t);
      logic [31:0] exp_a;
      logic [31:0] exp_b;
      // inputs still hold this entry's operands
      exp_a = t.flags[1] ? pc : rs1_data;
      exp_b = t.flags[2] ? t.imm : rs2_data;
      check(t.name, "unit valids", 32'(t.flags[10:7]), 32'({ctrl_e.alu.valid,
            ctrl_e.lsu.valid, ctrl_e.bru.valid, ctrl_e.mul.valid}));
      check(t.name, "wens", 32'(t.flags[6:3]), 32'({ctrl_e.alu.wen, ctrl_e.lsu.wen,
            ctrl_e.mul.wen, ctrl_e.bru.link_wen}));
      check(t.name, "b_imm", 32'(t.flags[2]), 32'(ctrl_e.alu.b_imm));
      check(t.name, "exception", 32'({t.flags[0], t.code}),
            32'({ctrl_e.exc.exception, ctrl_e.exc.exccode}));
      check(t.name, "ops", 32'(t.ops), 32'({ctrl_e.alu.op, ctrl_e.lsu.op, ctrl_e.bru.op,
            ctrl_e.mul.is_signed, ctrl_e.mul.hi}));
      check(t.name, "target", 32'(t.target), 32'(ctrl_e.alu.target));
      check(t.name, "lsu rd", 32'(t.target), 32'(ctrl_e.lsu.rd));
      check(t.name, "rs1", 32'(t.rs1), 32'(ctrl_e.rs1));
      check(t.name, "rs2", 32'(t.rs2), 32'(ctrl_e.rs2));
      check(t.name, "lsu imm", t.imm, ctrl_e.lsu.imm);
      check(t.name, "bru offset", t.imm, ctrl_e.bru.offset);
      check(t.name, "alu a", exp_a, ctrl_e.alu.a);
      check(t.name, "alu b", exp_b, ctrl_e.alu.b);
   endtask

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      // a valid add during reset must not come out
      inst       = {`OP_ADD_W, 5'd1, 5'd2, 5'd3};
      pc         = '0;
      inst_valid = 1'b1;
      rs1_data   = '0;
      rs2_data   = '0;
      build_table();

      repeat (2) @(posedge clk);
      #1;
      check("reset", "flags", 32'(0), 32'({ctrl_e.alu.valid, ctrl_e.alu.wen,
            ctrl_e.lsu.valid, ctrl_e.lsu.wen, ctrl_e.bru.valid, ctrl_e.bru.link_wen,
            ctrl_e.mul.valid, ctrl_e.mul.wen, ctrl_e.exc.exception}));
      rst_n = 1'b1;

      for (int i = 0; i < cases.size(); i++) begin
         inst       = cases[i].word;
         inst_valid = cases[i].valid;
         pc         = rand_word();
         rs1_data   = rand_word();
         rs2_data   = rand_word();
         #10;
         check(cases[i].name, "rs1 addr", 32'(cases[i].rs1), 32'(rs1_addr));
         check(cases[i].name, "rs2 addr", 32'(cases[i].rs2), 32'(rs2_addr));
         @(posedge clk);
         #1;
         check_ctrl(cases[i]);
      end

      $display("Simulation finished: PASS");
      $finish;
   end

   // watchdog
   initial begin
      #1;
      #((cases.size() + 10) * 100);
      $display("timeout: the stimulus table did not complete in time");
      $display("Simulation finished: FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

//--- idu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "idu_defs.svh"

module idu_top
   import idu_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [31:0]          inst,
   input  logic [`GRLEN-1:0]    pc,
   input  logic                 inst_valid,
   input  logic [`GRLEN-1:0]    rs1_data,
   input  logic [`GRLEN-1:0]    rs2_data,
   output logic [`REG_BITS-1:0] rs1_addr,
   output logic [`REG_BITS-1:0] rs2_addr,
   output exec_ctrl_t           ctrl_e
);

   dec_op_t           dec_op;
   logic [`GRLEN-1:0] imm;
   exec_ctrl_t        ctrl_d;

   inst_decoder inst_decoder_inst (
      .inst   (inst),
      .dec_op (dec_op)
   );

   imm_gen imm_gen_inst (
      .inst     (inst),
      .imm_kind (dec_op.imm_kind),
      .imm      (imm)
   );

   // register file answers rs1/rs2 in this same cycle
   issue_ctrl issue_ctrl_inst (
      .dec_op     (dec_op),
      .inst       (inst),
      .imm        (imm),
      .pc         (pc),
      .inst_valid (inst_valid),
      .rs1_data   (rs1_data),
      .rs2_data   (rs2_data),
      .rs1_addr   (rs1_addr),
      .rs2_addr   (rs2_addr),
      .ctrl_d     (ctrl_d)
   );

   d2e_stage d2e_stage_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .ctrl_d (ctrl_d),
      .ctrl_e (ctrl_e)
   );

endmodule

`default_nettype wire

//--- d2e_stage.sv
`timescale 1ns/10ps
`default_nettype none

module d2e_stage
   import idu_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  exec_ctrl_t ctrl_d,
   output exec_ctrl_t ctrl_e
);

   ////////////////////////////////////////
   // decode to execute register
   ////////////////////////////////////////

   // whole bundle moves every cycle, no stall
   always_ff @(posedge clk) begin
      ctrl_e <= ctrl_d;

      // control flags only, operands and codes keep flowing
      if (!rst_n) begin
         // alu
         ctrl_e.alu.valid <= 1'b0;
         ctrl_e.alu.wen   <= 1'b0;

         // lsu
         ctrl_e.lsu.valid <= 1'b0;
         ctrl_e.lsu.wen   <= 1'b0;

         // bru
         ctrl_e.bru.valid    <= 1'b0;
         ctrl_e.bru.link_wen <= 1'b0;

         // mul
         ctrl_e.mul.valid <= 1'b0;
         ctrl_e.mul.wen   <= 1'b0;

         // no exception out of reset
         ctrl_e.exc.exception <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- issue_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "idu_defs.svh"

module issue_ctrl
   import idu_pkg::*;
(
   input  dec_op_t              dec_op,
   input  inst_word_u           inst,
   input  logic [`GRLEN-1:0]    imm,
   input  logic [`GRLEN-1:0]    pc,
   input  logic                 inst_valid,
   input  logic [`GRLEN-1:0]    rs1_data,
   input  logic [`GRLEN-1:0]    rs2_data,
   output logic [`REG_BITS-1:0] rs1_addr,
   output logic [`REG_BITS-1:0] rs2_addr,
   output exec_ctrl_t           ctrl_d
);

   logic                 exc_any;
   logic                 go;
   logic                 alu_go;
   logic                 lsu_go;
   logic                 bru_go;
   logic                 mul_go;
   logic                 is_bl;
   logic [`REG_BITS-1:0] target;

   ////////////////////////////////////////
   // exceptions and dispatch
   ////////////////////////////////////////

   assign exc_any = dec_op.is_syscall | dec_op.is_break | dec_op.is_ine;

   // killed or faulting words go nowhere
   assign go     = inst_valid & ~exc_any;
   assign alu_go = go & (dec_op.unit == UNIT_ALU);
   assign lsu_go = go & (dec_op.unit == UNIT_LSU);
   assign bru_go = go & (dec_op.unit == UNIT_BRU);
   assign mul_go = go & (dec_op.unit == UNIT_MUL);

   ////////////////////////////////////////
   // register numbers
   ////////////////////////////////////////

   assign is_bl    = (dec_op.unit == UNIT_BRU) && (dec_op.bru_op == BRU_BL);
   assign rs1_addr = inst.r3.rj;
   assign rs2_addr = dec_op.rd_read ? inst.r3.rd : inst.r3.rk;
   // bl links into r1
   assign target   = is_bl ? {{(`REG_BITS-1){1'b0}}, 1'b1} : inst.r3.rd;

   always_comb begin
      ctrl_d.alu.valid     = alu_go;
      ctrl_d.alu.op        = dec_op.alu_op;
      ctrl_d.alu.b_imm     = (dec_op.imm_kind != IMM_NONE) & alu_go;
      ctrl_d.alu.a         = dec_op.pc_rel ? pc : rs1_data;
      ctrl_d.alu.b         = ctrl_d.alu.b_imm ? imm : rs2_data;
      ctrl_d.alu.wen       = dec_op.gr_wen & alu_go;
      ctrl_d.alu.target    = target;

      ctrl_d.lsu.valid     = lsu_go;
      ctrl_d.lsu.op        = dec_op.lsu_op;
      ctrl_d.lsu.imm       = imm;
      ctrl_d.lsu.wen       = dec_op.gr_wen & lsu_go;
      ctrl_d.lsu.rd        = target;

      ctrl_d.bru.valid     = bru_go;
      ctrl_d.bru.op        = dec_op.bru_op;
      ctrl_d.bru.offset    = imm;
      ctrl_d.bru.link_wen  = dec_op.gr_wen & bru_go;

      ctrl_d.mul.valid     = mul_go;
      ctrl_d.mul.wen       = dec_op.gr_wen & mul_go;
      ctrl_d.mul.is_signed = dec_op.mul_signed;
      ctrl_d.mul.hi        = dec_op.mul_hi;

      // syscall over break over ine
      ctrl_d.exc.exception = exc_any & inst_valid;
      ctrl_d.exc.exccode   = dec_op.is_syscall ? `EXC_SYS :
                             dec_op.is_break   ? `EXC_BRK :
                             dec_op.is_ine     ? `EXC_INE :
                                                 {`EXC_BITS{1'b0}};

      ctrl_d.rs1           = rs1_addr;
      ctrl_d.rs2           = rs2_addr;
   end

endmodule

`default_nettype wire

//--- imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "idu_defs.svh"

module imm_gen
   import idu_pkg::*;
(
   input  inst_word_u        inst,
   input  imm_kind_e         imm_kind,
   output logic [`GRLEN-1:0] imm
);

   logic [25:0] offs26;

   // bl offset, inst[9:0] is the upper part
   assign offs26 = {inst.ri16.rj, inst.ri16.rd, inst.ri16.offs16};

   always_comb begin
      case (imm_kind)
         IMM_SI12:
            imm = {{(`GRLEN-12){inst.ri12.si12[11]}}, inst.ri12.si12};
         IMM_SI20_HI:
            imm = {inst.ri20.si20, 12'b0};
         // branch offsets are word aligned
         IMM_OFFS16:
            imm = {{(`GRLEN-18){inst.ri16.offs16[15]}}, inst.ri16.offs16, 2'b00};
         IMM_OFFS26:
            imm = {{(`GRLEN-28){offs26[25]}}, offs26, 2'b00};
         default:
            imm = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "idu_defs.svh"

module inst_decoder
   import idu_pkg::*;
(
   input  inst_word_u inst,
   output dec_op_t    dec_op
);

   always_comb begin
      dec_op          = '0;
      dec_op.unit     = UNIT_NONE;
      dec_op.alu_op   = ALU_ADD;
      dec_op.lsu_op   = LSU_LOAD_W;
      dec_op.bru_op   = BRU_BEQ;
      dec_op.imm_kind = IMM_NONE;

      // 3R ops first, then narrower opcode fields
      case (inst.r3.opcode)
         `OP_ADD_W, `OP_SUB_W, `OP_AND, `OP_OR, `OP_XOR: begin
            dec_op.unit   = UNIT_ALU;
            dec_op.gr_wen = 1'b1;
         end
         `OP_MUL_W, `OP_MULH_W, `OP_MULH_WU: begin
            dec_op.unit       = UNIT_MUL;
            dec_op.gr_wen     = 1'b1;
            dec_op.mul_signed = (inst.r3.opcode != `OP_MULH_WU);
            dec_op.mul_hi     = (inst.r3.opcode != `OP_MUL_W);
         end
         `OP_SYSCALL: dec_op.is_syscall = 1'b1;
         `OP_BREAK:   dec_op.is_break = 1'b1;
         default: begin
            case (inst.ri12.opcode)
               `OP_ADDI_W: begin
                  dec_op.unit     = UNIT_ALU;
                  dec_op.gr_wen   = 1'b1;
                  dec_op.imm_kind = IMM_SI12;
               end
               `OP_LD_W: begin
                  dec_op.unit     = UNIT_LSU;
                  dec_op.gr_wen   = 1'b1;
                  dec_op.imm_kind = IMM_SI12;
               end
               `OP_ST_W: begin
                  dec_op.unit     = UNIT_LSU;
                  dec_op.lsu_op   = LSU_STORE_W;
                  dec_op.rd_read  = 1'b1;
                  dec_op.imm_kind = IMM_SI12;
               end
               default: begin
                  if (inst.ri20.opcode == `OP_PCADDU12I) begin
                     dec_op.unit     = UNIT_ALU;
                     dec_op.gr_wen   = 1'b1;
                     dec_op.pc_rel   = 1'b1;
                     dec_op.imm_kind = IMM_SI20_HI;
                  end else begin
                     case (inst.ri16.opcode)
                        `OP_BL: begin
                           dec_op.unit     = UNIT_BRU;
                           dec_op.bru_op   = BRU_BL;
                           dec_op.gr_wen   = 1'b1;
                           dec_op.imm_kind = IMM_OFFS26;
                        end
                        `OP_BEQ, `OP_BNE: begin
                           dec_op.unit     = UNIT_BRU;
                           dec_op.bru_op   = (inst.ri16.opcode == `OP_BNE) ? BRU_BNE : BRU_BEQ;
                           dec_op.rd_read  = 1'b1;
                           dec_op.imm_kind = IMM_OFFS16;
                        end
                        // nothing matched
                        default: dec_op.is_ine = 1'b1;
                     endcase
                  end
               end
            endcase
         end
      endcase

      // alu sub-op only differs among the 3R logic/arith ops
      case (inst.r3.opcode)
         `OP_SUB_W: dec_op.alu_op = ALU_SUB;
         `OP_AND:   dec_op.alu_op = ALU_AND;
         `OP_OR:    dec_op.alu_op = ALU_OR;
         `OP_XOR:   dec_op.alu_op = ALU_XOR;
         default:   dec_op.alu_op = ALU_ADD;
      endcase
   end

endmodule

`default_nettype wire

//--- idu_pkg.sv
`default_nettype none

`include "idu_defs.svh"

package idu_pkg;

   ////////////////////////////////////////
   // instruction word views
   ////////////////////////////////////////

   typedef struct packed {
      logic [16:0]          opcode;
      logic [`REG_BITS-1:0] rk;
      logic [`REG_BITS-1:0] rj;
      logic [`REG_BITS-1:0] rd;
   } inst_r3_t;

   typedef struct packed {
      logic [9:0]           opcode;
      logic [11:0]          si12;
      logic [`REG_BITS-1:0] rj;
      logic [`REG_BITS-1:0] rd;
   } inst_ri12_t;

   typedef struct packed {
      logic [6:0]           opcode;
      logic [19:0]          si20;
      logic [`REG_BITS-1:0] rd;
   } inst_ri20_t;

   // for bl, rj and rd carry offs[25:16]
   typedef struct packed {
      logic [5:0]           opcode;
      logic [15:0]          offs16;
      logic [`REG_BITS-1:0] rj;
      logic [`REG_BITS-1:0] rd;
   } inst_ri16_t;

   typedef union packed {
      inst_r3_t   r3;
      inst_ri12_t ri12;
      inst_ri20_t ri20;
      inst_ri16_t ri16;
   } inst_word_u;

   ////////////////////////////////////////
   // operation codes
   ////////////////////////////////////////

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;
   typedef enum logic [0:0] {LSU_LOAD_W, LSU_STORE_W} lsu_op_e;
   typedef enum logic [1:0] {BRU_BEQ, BRU_BNE, BRU_BL} bru_op_e;
   typedef enum logic [2:0] {UNIT_ALU, UNIT_LSU, UNIT_BRU, UNIT_MUL, UNIT_NONE} unit_e;
   typedef enum logic [2:0] {
      IMM_NONE, IMM_SI12, IMM_SI20_HI, IMM_OFFS16, IMM_OFFS26
   } imm_kind_e;

   typedef struct packed {
      unit_e     unit;
      alu_op_e   alu_op;
      lsu_op_e   lsu_op;
      bru_op_e   bru_op;
      logic      mul_signed;
      logic      mul_hi;
      imm_kind_e imm_kind;
      logic      pc_rel;
      // rs2 taken from rd
      logic      rd_read;
      logic      gr_wen;
      logic      is_syscall;
      logic      is_break;
      logic      is_ine;
   } dec_op_t;

   ////////////////////////////////////////
   // decode to execute controls
   ////////////////////////////////////////

   typedef struct packed {
      logic                 valid;
      alu_op_e              op;
      logic [`GRLEN-1:0]    a;
      logic [`GRLEN-1:0]    b;
      logic                 b_imm;
      logic                 wen;
      logic [`REG_BITS-1:0] target;
   } alu_ctrl_t;

   typedef struct packed {
      logic                 valid;
      lsu_op_e              op;
      logic [`GRLEN-1:0]    imm;
      logic                 wen;
      logic [`REG_BITS-1:0] rd;
   } lsu_ctrl_t;

   typedef struct packed {
      logic              valid;
      bru_op_e           op;
      logic [`GRLEN-1:0] offset;
      logic              link_wen;
   } bru_ctrl_t;

   typedef struct packed {
      logic valid;
      logic wen;
      logic is_signed;
      logic hi;
   } mul_ctrl_t;

   typedef struct packed {
      logic                 exception;
      logic [`EXC_BITS-1:0] exccode;
   } exc_t;

   typedef struct packed {
      alu_ctrl_t            alu;
      lsu_ctrl_t            lsu;
      bru_ctrl_t            bru;
      mul_ctrl_t            mul;
      exc_t                 exc;
      logic [`REG_BITS-1:0] rs1;
      logic [`REG_BITS-1:0] rs2;
   } exec_ctrl_t;

endpackage

`default_nettype wire

//--- idu_defs.svh
`ifndef IDU_DEFS_SVH
`define IDU_DEFS_SVH

// datapath and register file widths
`define GRLEN       32
`define REG_BITS    5
`define EXC_BITS    6

// exception codes
`define EXC_SYS     6'h0B
`define EXC_BRK     6'h0C
`define EXC_INE     6'h0D

// 3R format, inst[31:15]
`define OP_ADD_W    17'h00020
`define OP_SUB_W    17'h00022
`define OP_AND      17'h00029
`define OP_OR       17'h0002A
`define OP_XOR      17'h0002B
`define OP_MUL_W    17'h00038
`define OP_MULH_W   17'h00039
`define OP_MULH_WU  17'h0003A
`define OP_BREAK    17'h00054
`define OP_SYSCALL  17'h00056

// 2RI12 format, inst[31:22]
`define OP_ADDI_W   10'h00A
`define OP_LD_W     10'h0A2
`define OP_ST_W     10'h0A6

// 1RI20 format, inst[31:25]
`define OP_PCADDU12I 7'h0E

// branch format, inst[31:26]
`define OP_BL       6'h15
`define OP_BEQ      6'h16
`define OP_BNE      6'h17

`endif
